// ==== verilog/wisc_pkg.sv ====
package wisc_pkg;

	localparam int WORD_W = 16;
	localparam int REG_AW = 4;

	// opcodes of the kept subset, encodings as in the full WISC ISA
	localparam logic [3:0] OP_ADD = 4'd0;
	localparam logic [3:0] OP_SUB = 4'd1;
	localparam logic [3:0] OP_XOR = 4'd3;
	localparam logic [3:0] OP_SLL = 4'd4;
	localparam logic [3:0] OP_SRA = 4'd5;
	localparam logic [3:0] OP_ROR = 4'd6;
	localparam logic [3:0] OP_LW  = 4'd8;
	localparam logic [3:0] OP_SW  = 4'd9;
	localparam logic [3:0] OP_LHB = 4'd10;
	localparam logic [3:0] OP_LLB = 4'd11;
	localparam logic [3:0] OP_B   = 4'd12;
	localparam logic [3:0] OP_HLT = 4'd15;

	// branch condition codes
	localparam logic [2:0] CC_NE = 3'd0;
	localparam logic [2:0] CC_EQ = 3'd1;
	localparam logic [2:0] CC_GT = 3'd2;
	localparam logic [2:0] CC_LT = 3'd3;
	localparam logic [2:0] CC_GE = 3'd4;
	localparam logic [2:0] CC_LE = 3'd5;
	localparam logic [2:0] CC_OV = 3'd6;
	localparam logic [2:0] CC_UN = 3'd7;

	// bit positions in the flag word
	localparam int FLAG_Z = 0;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 2;

	// execute operand sources
	localparam logic [1:0] FWD_REG = 2'd0;
	localparam logic [1:0] FWD_WB  = 2'd1;
	localparam logic [1:0] FWD_MEM = 2'd2;

endpackage

// ==== verilog/wisc_mem.sv ====
module wisc_mem #(
	parameter int ADDR_W = 8
) (
	input  logic              clk_i,
	input  logic              we_i,
	input  logic [ADDR_W-1:0] waddr_i,
	input  logic [ADDR_W-1:0] raddr_i,
	input  logic [15:0]       wdata_i,
	output logic [15:0]       rdata_o
);

	logic [15:0] mem_q [0:(2**ADDR_W)-1];

	always_ff @(posedge clk_i) begin
		if (we_i) begin
			mem_q[waddr_i] <= wdata_i;
		end
	end

	// read is combinational so fetch and the MEM stage see data in the same cycle
	assign rdata_o = mem_q[raddr_i];

endmodule

// ==== verilog/wisc_regfile.sv ====
module wisc_regfile (
	input  logic                          clk_i,
	input  logic                          rst_n_i,
	input  logic [wisc_pkg::REG_AW-1:0]   rs_i,
	input  logic [wisc_pkg::REG_AW-1:0]   rt_i,
	input  logic [wisc_pkg::REG_AW-1:0]   rd_i,
	input  logic                          we_i,
	input  logic [wisc_pkg::WORD_W-1:0]   wdata_i,
	output logic [wisc_pkg::WORD_W-1:0]   rs_data_o,
	output logic [wisc_pkg::WORD_W-1:0]   rt_data_o
);

	logic [wisc_pkg::WORD_W-1:0] regs_q [1:(2**wisc_pkg::REG_AW)-1];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < 2**wisc_pkg::REG_AW; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && rd_i != '0) begin
			regs_q[rd_i] <= wdata_i;
		end
	end

	// the write-back value bypasses the array so decode sees it in the same cycle
	function automatic logic [wisc_pkg::WORD_W-1:0] read_port(
		input logic [wisc_pkg::REG_AW-1:0] idx
	);
		if (idx == '0) begin
			return '0;
		end else if (we_i && idx == rd_i) begin
			return wdata_i;
		end
		return regs_q[idx];
	endfunction

	assign rs_data_o = read_port(rs_i);
	assign rt_data_o = read_port(rt_i);

endmodule

// ==== verilog/wisc_alu.sv ====
module wisc_alu (
	input  logic [3:0]  op_i,
	input  logic [15:0] a_i,
	input  logic [15:0] b_i,
	input  logic [15:0] imm_i,
	output logic [15:0] result_o,
	output logic [15:0] addr_o,
	output logic [2:0]  flags_o,
	output logic [2:0]  flags_we_o
);

	logic [15:0] sum;
	logic [15:0] diff;
	logic        add_ov;
	logic        sub_ov;
	logic        ov;
	logic [3:0]  shamt;
	logic [31:0] rot_full;

	assign sum    = a_i + b_i;
	assign diff   = a_i - b_i;
	assign add_ov = (a_i[15] == b_i[15]) && (sum[15] != a_i[15]);
	assign sub_ov = (a_i[15] != b_i[15]) && (diff[15] != a_i[15]);
	assign shamt  = imm_i[3:0];
	assign rot_full = {a_i, a_i} >> shamt;

	// word address with bit 0 dropped, offset counts halfwords
	assign addr_o = {a_i[15:1], 1'b0} + {imm_i[14:0], 1'b0};

	always_comb begin
		result_o   = '0;
		flags_we_o = '0;
		ov         = 1'b0;
		case (op_i)
			wisc_pkg::OP_ADD: begin
				// on overflow the result clamps toward the sign of the operands
				result_o   = add_ov ? (a_i[15] ? 16'h8000 : 16'h7fff) : sum;
				ov         = add_ov;
				flags_we_o = '1;
			end
			wisc_pkg::OP_SUB: begin
				result_o   = sub_ov ? (a_i[15] ? 16'h8000 : 16'h7fff) : diff;
				ov         = sub_ov;
				flags_we_o = '1;
			end
			wisc_pkg::OP_XOR: begin
				result_o                   = a_i ^ b_i;
				flags_we_o[wisc_pkg::FLAG_Z] = 1'b1;
			end
			wisc_pkg::OP_SLL: begin
				result_o                   = a_i << shamt;
				flags_we_o[wisc_pkg::FLAG_Z] = 1'b1;
			end
			wisc_pkg::OP_SRA: begin
				result_o                   = $signed(a_i) >>> shamt;
				flags_we_o[wisc_pkg::FLAG_Z] = 1'b1;
			end
			wisc_pkg::OP_ROR: begin
				result_o                   = rot_full[15:0];
				flags_we_o[wisc_pkg::FLAG_Z] = 1'b1;
			end
			wisc_pkg::OP_LLB: result_o = {a_i[15:8], imm_i[7:0]};
			wisc_pkg::OP_LHB: result_o = {imm_i[7:0], a_i[7:0]};
			default: ;
		endcase
	end

	assign flags_o[wisc_pkg::FLAG_Z] = (result_o == '0);
	assign flags_o[wisc_pkg::FLAG_V] = ov;
	assign flags_o[wisc_pkg::FLAG_N] = result_o[15];

endmodule

// ==== verilog/wisc_branch.sv ====
module wisc_branch (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic [2:0]  flags_i,
	input  logic [2:0]  flags_we_i,
	input  logic [3:0]  op_i,
	input  logic [2:0]  ccode_i,
	input  logic [15:0] pc_i,
	input  logic [8:0]  offset_i,
	output logic        taken_o,
	output logic [15:0] target_o
);

	logic [2:0] flags_q;
	logic       z;
	logic       v;
	logic       n;
	logic       cond;

	// each flag keeps its value until an instruction that owns it writes it
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			flags_q <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (flags_we_i[i]) begin
					flags_q[i] <= flags_i[i];
				end
			end
		end
	end

	assign z = flags_q[wisc_pkg::FLAG_Z];
	assign v = flags_q[wisc_pkg::FLAG_V];
	assign n = flags_q[wisc_pkg::FLAG_N];

	always_comb begin
		case (ccode_i)
			wisc_pkg::CC_NE: cond = !z;
			wisc_pkg::CC_EQ: cond = z;
			wisc_pkg::CC_GT: cond = !z && !n;
			wisc_pkg::CC_LT: cond = n;
			wisc_pkg::CC_GE: cond = z || !n;
			wisc_pkg::CC_LE: cond = n || z;
			wisc_pkg::CC_OV: cond = v;
			wisc_pkg::CC_UN: cond = 1'b1;
			default:         cond = 1'b0;
		endcase
	end

	assign taken_o  = (op_i == wisc_pkg::OP_B) && cond;
	assign target_o = pc_i + 16'd2 + {{6{offset_i[8]}}, offset_i, 1'b0};

endmodule

// ==== verilog/wisc_hazard.sv ====
module wisc_hazard (
	input  logic [wisc_pkg::REG_AW-1:0] idex_rs_i,
	input  logic [wisc_pkg::REG_AW-1:0] idex_rt_i,
	input  logic [wisc_pkg::REG_AW-1:0] exmem_rd_i,
	input  logic [wisc_pkg::REG_AW-1:0] memwb_rd_i,
	input  logic [wisc_pkg::REG_AW-1:0] ifid_rs_i,
	input  logic [wisc_pkg::REG_AW-1:0] ifid_rt_i,
	input  logic                        exmem_we_i,
	input  logic                        memwb_we_i,
	input  logic                        idex_load_i,
	output logic [1:0]                  fwd_a_o,
	output logic [1:0]                  fwd_b_o,
	output logic                        stall_o
);

	// the younger result in EX/MEM takes priority over MEM/WB
	function automatic logic [1:0] fwd_sel(input logic [wisc_pkg::REG_AW-1:0] src);
		if (exmem_we_i && exmem_rd_i != '0 && exmem_rd_i == src) begin
			return wisc_pkg::FWD_MEM;
		end else if (memwb_we_i && memwb_rd_i != '0 && memwb_rd_i == src) begin
			return wisc_pkg::FWD_WB;
		end
		return wisc_pkg::FWD_REG;
	endfunction

	assign fwd_a_o = fwd_sel(idex_rs_i);
	assign fwd_b_o = fwd_sel(idex_rt_i);

	// for a load, the rt field names the destination register
	assign stall_o = idex_load_i && idex_rt_i != '0 &&
		(idex_rt_i == ifid_rs_i || idex_rt_i == ifid_rt_i);

endmodule

// ==== verilog/wisc_cpu.sv ====
module wisc_cpu #(
	parameter int IMEM_AW = 8,
	parameter int DMEM_AW = 8
) (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic                        run_i,
	input  logic                        load_we_i,
	input  logic                        load_sel_i,
	input  logic [15:0]                 load_addr_i,
	input  logic [15:0]                 load_data_i,
	output logic [15:0]                 pc_o,
	output logic                        hlt_o,
	output logic                        wb_en_o,
	output logic [wisc_pkg::REG_AW-1:0] wb_reg_o,
	output logic [wisc_pkg::WORD_W-1:0] wb_data_o
);

	localparam int W = wisc_pkg::WORD_W;
	localparam int R = wisc_pkg::REG_AW;

	logic [W-1:0] pc_q, imem_rdata, dmem_rdata, wb_data;
	logic         stall, fetch_hlt;
	logic         ifid_valid;
	logic [W-1:0] ifid_instr, ifid_pc;
	logic [3:0]   dec_op;
	logic [R-1:0] dec_rs, dec_rt, dec_rd;
	logic         dec_we;
	logic [W-1:0] dec_imm, rs_data, rt_data;
	logic         idex_valid, idex_we;
	logic [3:0]   idex_op;
	logic [R-1:0] idex_rs, idex_rt, idex_rd;
	logic [W-1:0] idex_a, idex_b, idex_imm, idex_pc;
	logic [2:0]   idex_ccode;
	logic [8:0]   idex_off;
	logic         ex_valid, br_taken;
	logic [1:0]   fwd_a, fwd_b;
	logic [W-1:0] op_a, op_b, alu_result, alu_addr, br_target;
	logic [2:0]   alu_flags, alu_flags_we;
	logic         exmem_valid, exmem_we, exmem_br;
	logic [3:0]   exmem_op;
	logic [R-1:0] exmem_rd;
	logic [W-1:0] exmem_result, exmem_addr, exmem_sdata, exmem_target;
	logic         memwb_we, memwb_load, memwb_hlt, hlt_q;
	logic [R-1:0] memwb_rd;
	logic [W-1:0] memwb_result, memwb_mdata;

	// fetch holds on a fetched HLT, only a branch redirect can move it again
	assign fetch_hlt = imem_rdata[15:12] == wisc_pkg::OP_HLT;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q <= '0;
		end else if (exmem_br) begin
			pc_q <= exmem_target;
		end else if (run_i && !stall && !fetch_hlt) begin
			pc_q <= pc_q + 16'd2;
		end
	end

	wisc_mem #(.ADDR_W(IMEM_AW)) u_imem (
		.clk_i(clk_i), .we_i(load_we_i && !run_i && !load_sel_i),
		.waddr_i(load_addr_i[IMEM_AW-1:0]), .raddr_i(pc_q[IMEM_AW:1]),
		.wdata_i(load_data_i), .rdata_o(imem_rdata)
	);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ifid_valid <= 1'b0;
		end else if (exmem_br || !run_i) begin
			ifid_valid <= 1'b0;
		end else if (!stall) begin
			ifid_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!stall) begin
			ifid_instr <= imem_rdata;
			ifid_pc    <= pc_q;
		end
	end

	// unused source fields read R0 so they never forward or stall
	always_comb begin
		dec_op  = ifid_instr[15:12];
		dec_rd  = ifid_instr[11:8];
		dec_rs  = '0;
		dec_rt  = '0;
		dec_we  = 1'b0;
		dec_imm = {{12{ifid_instr[3]}}, ifid_instr[3:0]};
		if (dec_op == wisc_pkg::OP_LLB || dec_op == wisc_pkg::OP_LHB) begin
			dec_imm = {8'h00, ifid_instr[7:0]};
		end
		if (ifid_valid) begin
			case (dec_op)
				wisc_pkg::OP_ADD, wisc_pkg::OP_SUB, wisc_pkg::OP_XOR: begin
					dec_rs = ifid_instr[7:4];
					dec_rt = ifid_instr[3:0];
					dec_we = 1'b1;
				end
				wisc_pkg::OP_SLL, wisc_pkg::OP_SRA, wisc_pkg::OP_ROR: begin
					dec_rs = ifid_instr[7:4];
					dec_we = 1'b1;
				end
				wisc_pkg::OP_LW, wisc_pkg::OP_SW: begin
					dec_rs = ifid_instr[7:4];
					dec_rt = ifid_instr[11:8];
					dec_we = dec_op == wisc_pkg::OP_LW;
				end
				wisc_pkg::OP_LLB, wisc_pkg::OP_LHB: begin
					dec_rs = ifid_instr[11:8];
					dec_we = 1'b1;
				end
				default: ;
			endcase
		end
	end

	wisc_regfile u_regfile (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .rs_i(dec_rs), .rt_i(dec_rt), .rd_i(memwb_rd),
		.we_i(memwb_we), .wdata_i(wb_data), .rs_data_o(rs_data), .rt_data_o(rt_data)
	);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			idex_valid <= 1'b0;
			idex_we    <= 1'b0;
		end else begin
			idex_valid <= ifid_valid && !exmem_br && !stall;
			idex_we    <= dec_we && dec_rd != '0 && !exmem_br && !stall;
		end
	end

	always_ff @(posedge clk_i) begin
		idex_op    <= dec_op;
		idex_rs    <= dec_rs;
		idex_rt    <= dec_rt;
		idex_rd    <= dec_rd;
		idex_a     <= rs_data;
		idex_b     <= rt_data;
		idex_imm   <= dec_imm;
		idex_pc    <= ifid_pc;
		idex_ccode <= ifid_instr[11:9];
		idex_off   <= ifid_instr[8:0];
	end

	wisc_hazard u_hazard (
		.idex_rs_i(idex_rs), .idex_rt_i(idex_rt), .exmem_rd_i(exmem_rd),
		.memwb_rd_i(memwb_rd), .ifid_rs_i(dec_rs), .ifid_rt_i(dec_rt),
		.exmem_we_i(exmem_we), .memwb_we_i(memwb_we),
		.idex_load_i(idex_valid && idex_op == wisc_pkg::OP_LW),
		.fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .stall_o(stall)
	);

	// the instruction in execute dies when the branch ahead of it redirects
	assign ex_valid = idex_valid && !exmem_br;

	always_comb begin
		case (fwd_a)
			wisc_pkg::FWD_MEM: op_a = exmem_result;
			wisc_pkg::FWD_WB:  op_a = wb_data;
			default:           op_a = idex_a;
		endcase
		case (fwd_b)
			wisc_pkg::FWD_MEM: op_b = exmem_result;
			wisc_pkg::FWD_WB:  op_b = wb_data;
			default:           op_b = idex_b;
		endcase
	end

	wisc_alu u_alu (
		.op_i(idex_op), .a_i(op_a), .b_i(op_b), .imm_i(idex_imm), .result_o(alu_result),
		.addr_o(alu_addr), .flags_o(alu_flags), .flags_we_o(alu_flags_we)
	);

	wisc_branch u_branch (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .flags_i(alu_flags),
		.flags_we_i(alu_flags_we & {3{ex_valid}}), .op_i(idex_op), .ccode_i(idex_ccode),
		.pc_i(idex_pc), .offset_i(idex_off), .taken_o(br_taken), .target_o(br_target)
	);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			exmem_valid <= 1'b0;
			exmem_we    <= 1'b0;
			exmem_br    <= 1'b0;
		end else begin
			exmem_valid <= ex_valid;
			exmem_we    <= idex_we && ex_valid;
			exmem_br    <= br_taken && ex_valid;
		end
	end

	always_ff @(posedge clk_i) begin
		exmem_op     <= idex_op;
		exmem_rd     <= idex_rd;
		exmem_result <= alu_result;
		exmem_addr   <= alu_addr;
		exmem_sdata  <= op_b;
		exmem_target <= br_target;
	end

	// the load port owns the data memory write side while the core is idle
	wisc_mem #(.ADDR_W(DMEM_AW)) u_dmem (
		.clk_i(clk_i),
		.we_i(run_i ? (exmem_valid && exmem_op == wisc_pkg::OP_SW) : (load_we_i && load_sel_i)),
		.waddr_i(run_i ? exmem_addr[DMEM_AW:1] : load_addr_i[DMEM_AW-1:0]),
		.raddr_i(exmem_addr[DMEM_AW:1]),
		.wdata_i(run_i ? exmem_sdata : load_data_i), .rdata_o(dmem_rdata)
	);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			memwb_we   <= 1'b0;
			memwb_load <= 1'b0;
			memwb_hlt  <= 1'b0;
			hlt_q      <= 1'b0;
		end else begin
			memwb_we   <= exmem_we;
			memwb_load <= exmem_valid && exmem_op == wisc_pkg::OP_LW;
			memwb_hlt  <= exmem_valid && exmem_op == wisc_pkg::OP_HLT;
			hlt_q      <= hlt_q || memwb_hlt;
		end
	end

	always_ff @(posedge clk_i) begin
		memwb_rd     <= exmem_rd;
		memwb_result <= exmem_result;
		memwb_mdata  <= dmem_rdata;
	end

	assign wb_data   = memwb_load ? memwb_mdata : memwb_result;
	assign pc_o      = pc_q;
	assign hlt_o     = hlt_q || memwb_hlt;
	assign wb_en_o   = memwb_we;
	assign wb_reg_o  = memwb_rd;
	assign wb_data_o = wb_data;

endmodule

// ==== sim/wisc_cpu_props.sv ====
module wisc_cpu_props (
	input logic       clk_i,
	input logic       rst_n_i,
	input logic       run_i,
	input logic       hlt_i,
	input logic       wb_en_i,
	input logic [3:0] wb_reg_i
);

	int fail_cnt = 0;

	// nothing retires while the core is held for loading
	idle_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!run_i |-> !wb_en_i)
		else begin
			fail_cnt++;
			$error("wb_en_o high while run_i is low");
		end

	// only reset clears the halt state
	halt_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		hlt_i |=> hlt_i)
		else begin
			fail_cnt++;
			$error("hlt_o dropped without a reset");
		end

	no_r0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_en_i |-> wb_reg_i != '0)
		else begin
			fail_cnt++;
			$error("wb_en_o high with wb_reg_o at R0");
		end

endmodule

bind wisc_cpu wisc_cpu_props u_props (
	.clk_i(clk_i), .rst_n_i(rst_n_i), .run_i(run_i),
	.hlt_i(hlt_o), .wb_en_i(wb_en_o), .wb_reg_i(wb_reg_o)
);

// ==== sim/wisc_checker.sv ====
module wisc_checker #(
	parameter int IMEM_AW = 8,
	parameter int DMEM_AW = 8
) (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        run_i,
	input  logic        load_we_i,
	input  logic        load_sel_i,
	input  logic [15:0] load_addr_i,
	input  logic [15:0] load_data_i,
	input  logic [15:0] pc_i,
	input  logic        hlt_i,
	input  logic        wb_en_i,
	input  logic [3:0]  wb_reg_i,
	input  logic [15:0] wb_data_i,
	output int          chk_cnt_o,
	output int          err_cnt_o
);

	logic [15:0] imem_img [0:(2**IMEM_AW)-1];
	logic [15:0] dmem_img [0:(2**DMEM_AW)-1];
	logic [3:0]  exp_reg_q [$];
	logic [15:0] exp_data_q [$];
	logic [15:0] exp_hlt_pc;
	logic        model_done;
	logic        hlt_seen;

	initial begin
		chk_cnt_o = 0;
		err_cnt_o = 0;
	end

	function automatic logic [15:0] saturate(input int s);
		if (s > 32767) begin
			return 16'h7fff;
		end
		if (s < -32768) begin
			return 16'h8000;
		end
		return 16'(s);
	endfunction

	function automatic logic cond_met(input logic [2:0] cc, input logic z, input logic v,
		input logic n);
		case (cc)
			wisc_pkg::CC_NE: return !z;
			wisc_pkg::CC_EQ: return z;
			wisc_pkg::CC_GT: return !z && !n;
			wisc_pkg::CC_LT: return n;
			wisc_pkg::CC_GE: return z || !n;
			wisc_pkg::CC_LE: return z || n;
			wisc_pkg::CC_OV: return v;
			default:         return 1'b1;
		endcase
	endfunction

	// runs the loaded program to HLT and queues every register write it makes
	task automatic run_model();
		logic [15:0] regs [0:15];
		logic        fz;
		logic        fv;
		logic        fn;
		logic [15:0] pc;
		logic [15:0] ins;
		logic [15:0] a;
		logic [15:0] res;
		logic [15:0] addr;
		logic [3:0]  op;
		logic [3:0]  rd;
		logic [3:0]  sh;
		logic        wr;
		int          s;
		int          steps;
		int          r;
		for (r = 0; r < 16; r++) begin
			regs[r] = '0;
		end
		fz = 1'b0;
		fv = 1'b0;
		fn = 1'b0;
		pc = '0;
		steps = 0;
		while (steps < 4 * (2**IMEM_AW)) begin
			ins  = imem_img[pc[IMEM_AW:1]];
			op   = ins[15:12];
			rd   = ins[11:8];
			a    = regs[ins[7:4]];
			sh   = ins[3:0];
			addr = (a & 16'hfffe) + {{11{ins[3]}}, ins[3:0], 1'b0};
			wr   = 1'b0;
			res  = '0;
			steps++;
			if (op == wisc_pkg::OP_HLT) begin
				exp_hlt_pc = pc;
				return;
			end
			case (op)
				wisc_pkg::OP_ADD, wisc_pkg::OP_SUB: begin
					if (op == wisc_pkg::OP_ADD) begin
						s = int'($signed(a)) + int'($signed(regs[ins[3:0]]));
					end else begin
						s = int'($signed(a)) - int'($signed(regs[ins[3:0]]));
					end
					res = saturate(s);
					fz  = res == '0;
					fv  = s > 32767 || s < -32768;
					fn  = res[15];
					wr  = 1'b1;
				end
				wisc_pkg::OP_XOR: res = a ^ regs[ins[3:0]];
				wisc_pkg::OP_SLL: res = a << sh;
				wisc_pkg::OP_SRA: res = $signed(a) >>> sh;
				wisc_pkg::OP_ROR: res = (a >> sh) | (a << (16 - sh));
				wisc_pkg::OP_LW: begin
					res = dmem_img[addr[DMEM_AW:1]];
					wr  = 1'b1;
				end
				wisc_pkg::OP_SW: dmem_img[addr[DMEM_AW:1]] = regs[rd];
				wisc_pkg::OP_LLB: begin
					res = {regs[rd][15:8], ins[7:0]};
					wr  = 1'b1;
				end
				wisc_pkg::OP_LHB: begin
					res = {ins[7:0], regs[rd][7:0]};
					wr  = 1'b1;
				end
				wisc_pkg::OP_B: begin
					if (cond_met(ins[11:9], fz, fv, fn)) begin
						pc = pc + {{6{ins[8]}}, ins[8:0], 1'b0};
					end
				end
				default: ;
			endcase
			// logic ops and shifts only touch the zero flag
			if (op inside {wisc_pkg::OP_XOR, wisc_pkg::OP_SLL, wisc_pkg::OP_SRA,
				wisc_pkg::OP_ROR}) begin
				fz = res == '0;
				wr = 1'b1;
			end
			if (wr && rd != '0) begin
				regs[rd] = res;
				exp_reg_q.push_back(rd);
				exp_data_q.push_back(res);
			end
			pc = pc + 16'd2;
		end
		err_cnt_o++;
		$display("Error: reference model never reached HLT");
	endtask

	task automatic check_write();
		logic [3:0]  exp_reg;
		logic [15:0] exp_data;
		if (exp_reg_q.size() == 0) begin
			err_cnt_o++;
			$display("Error: register write to R%0d with no write left in the program", wb_reg_i);
			return;
		end
		exp_reg  = exp_reg_q.pop_front();
		exp_data = exp_data_q.pop_front();
		chk_cnt_o++;
		if (wb_reg_i !== exp_reg) begin
			err_cnt_o++;
			$display("Error: wb_reg_o = %h, expected %h", wb_reg_i, exp_reg);
		end
		if (wb_data_i !== exp_data) begin
			err_cnt_o++;
			$display("Error: wb_data_o = %h, expected %h", wb_data_i, exp_data);
		end
	endtask

	task automatic check_halt();
		if (!hlt_seen) begin
			hlt_seen = 1'b1;
			chk_cnt_o++;
			if (exp_reg_q.size() != 0) begin
				err_cnt_o++;
				$display("Error: halted with %0d register writes still missing",
					exp_reg_q.size());
			end
		end
		chk_cnt_o++;
		if (pc_i !== exp_hlt_pc) begin
			err_cnt_o++;
			$display("Error: pc_o = %h, expected %h", pc_i, exp_hlt_pc);
		end
	endtask

	// outputs are registered in the DUT, so the falling edge sees them settled
	always @(negedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			exp_reg_q.delete();
			exp_data_q.delete();
			model_done = 1'b0;
			hlt_seen   = 1'b0;
		end else begin
			if (load_we_i && !run_i) begin
				if (load_sel_i) begin
					dmem_img[load_addr_i[DMEM_AW-1:0]] = load_data_i;
				end else begin
					imem_img[load_addr_i[IMEM_AW-1:0]] = load_data_i;
				end
			end
			if (run_i && !model_done) begin
				run_model();
				model_done = 1'b1;
			end
			if (wb_en_i) begin
				check_write();
			end
			if (hlt_i) begin
				check_halt();
			end
		end
	end

endmodule

// ==== sim/tb_wisc_cpu.sv ====
module tb_wisc_cpu;

	localparam int IMEM_AW    = 8;
	localparam int DMEM_AW    = 8;
	localparam int NUM_PROGS  = 3;
	localparam int DATA_WORDS = 2**DMEM_AW;
	localparam int PROG_LEN   = 60;
	// data load, program load, up to three cycles per instruction, and some slack
	localparam int TIMEOUT_CYCLES = NUM_PROGS *
		(DATA_WORDS + (PROG_LEN + 1) + (PROG_LEN + 1) * 3 + 40);

	logic        clk;
	logic        rst_n;
	logic        run;
	logic        load_we;
	logic        load_sel;
	logic [15:0] load_addr;
	logic [15:0] load_data;
	logic [15:0] pc;
	logic        hlt;
	logic        wb_en;
	logic [3:0]  wb_reg;
	logic [15:0] wb_data;
	int          chk_cnt;
	int          err_cnt;
	int          cycle_cnt;
	integer      seed;
	logic [15:0] prog [0:PROG_LEN];

	wisc_cpu #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) dut (
		.clk_i(clk), .rst_n_i(rst_n), .run_i(run), .load_we_i(load_we),
		.load_sel_i(load_sel), .load_addr_i(load_addr), .load_data_i(load_data),
		.pc_o(pc), .hlt_o(hlt), .wb_en_o(wb_en), .wb_reg_o(wb_reg), .wb_data_o(wb_data)
	);

	wisc_checker #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) u_chk (
		.clk_i(clk), .rst_n_i(rst_n), .run_i(run), .load_we_i(load_we),
		.load_sel_i(load_sel), .load_addr_i(load_addr), .load_data_i(load_data),
		.pc_i(pc), .hlt_i(hlt), .wb_en_i(wb_en), .wb_reg_i(wb_reg), .wb_data_i(wb_data),
		.chk_cnt_o(chk_cnt), .err_cnt_o(err_cnt)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: the core did not halt within %0d cycles", cycle_cnt);
		$display("Simulation failed");
		$finish;
	end

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [15:0] encode(input logic [3:0] op, input int f2, input int f1,
		input int f0);
		return {op, 4'(f2), 4'(f1), 4'(f0)};
	endfunction

	task automatic reset_core();
		@(posedge clk);
		#1;
		rst_n   = 1'b0;
		run     = 1'b0;
		load_we = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic load_word(input logic sel, input int addr, input logic [15:0] data);
		@(posedge clk);
		#1;
		load_we   = 1'b1;
		load_sel  = sel;
		load_addr = 16'(addr);
		load_data = data;
	endtask

	// memory groups set a base with LLB/LHB so the address lands below 0x200
	task automatic generate_program();
		int i;
		int kind;
		int base;
		int dst;
		int off;
		i = 0;
		while (i < PROG_LEN) begin
			kind = rand_below(12);
			if (kind >= 10 && i + 4 > PROG_LEN) begin
				kind = 0;
			end
			base = 1 + rand_below(7);
			dst  = 1 + rand_below(7);
			off  = rand_below(16);
			case (kind)
				0: prog[i] = encode(wisc_pkg::OP_ADD, rand_below(8), rand_below(8), rand_below(8));
				1: prog[i] = encode(wisc_pkg::OP_SUB, rand_below(8), rand_below(8), rand_below(8));
				2: prog[i] = encode(wisc_pkg::OP_XOR, rand_below(8), rand_below(8), rand_below(8));
				3: prog[i] = encode(wisc_pkg::OP_SLL, rand_below(8), rand_below(8), off);
				4: prog[i] = encode(wisc_pkg::OP_SRA, rand_below(8), rand_below(8), off);
				5: prog[i] = encode(wisc_pkg::OP_ROR, rand_below(8), rand_below(8), off);
				6: prog[i] = encode(wisc_pkg::OP_LLB, rand_below(8), rand_below(16), off);
				7: prog[i] = encode(wisc_pkg::OP_LHB, rand_below(8), rand_below(16), off);
				8, 9: begin
					// forward only, the farthest target is the HLT
					prog[i] = {wisc_pkg::OP_B, 3'(rand_below(8)), 9'(rand_below(PROG_LEN - i))};
				end
				default: begin
					prog[i]     = encode(wisc_pkg::OP_LLB, base, 1 + rand_below(14), rand_below(16));
					prog[i + 1] = encode(wisc_pkg::OP_LHB, base, 0, rand_below(2));
					if (kind == 10) begin
						prog[i + 2] = encode(wisc_pkg::OP_SW, rand_below(8), base, off);
						prog[i + 3] = encode(wisc_pkg::OP_LW, rand_below(8), base, off);
					end else begin
						prog[i + 2] = encode(wisc_pkg::OP_LW, dst, base, off);
						prog[i + 3] = encode(wisc_pkg::OP_ADD, rand_below(8), dst, rand_below(8));
					end
					i = i + 3;
				end
			endcase
			i++;
		end
		prog[PROG_LEN] = {wisc_pkg::OP_HLT, 12'h000};
	endtask

	initial begin
		int total_err;
		seed      = 27;
		rst_n     = 1'b0;
		run       = 1'b0;
		load_we   = 1'b0;
		load_sel  = 1'b0;
		load_addr = '0;
		load_data = '0;
		for (int p = 0; p < NUM_PROGS; p++) begin
			reset_core();
			for (int a = 0; a < DATA_WORDS; a++) begin
				load_word(1'b1, a, 16'($random(seed)));
			end
			generate_program();
			for (int a = 0; a <= PROG_LEN; a++) begin
				load_word(1'b0, a, prog[a]);
			end
			@(posedge clk);
			#1;
			load_we = 1'b0;
			run     = 1'b1;
			while (hlt !== 1'b1) begin
				@(posedge clk);
				#1;
			end
			// stay halted for a few cycles so a late write or PC move would show
			repeat (4) @(posedge clk);
		end
		total_err = err_cnt + dut.u_props.fail_cnt;
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			chk_cnt, err_cnt, dut.u_props.fail_cnt);
		if (total_err == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== wisc_cpu.f ====
verilog/wisc_pkg.sv
verilog/wisc_mem.sv
verilog/wisc_regfile.sv
verilog/wisc_alu.sv
verilog/wisc_branch.sv
verilog/wisc_hazard.sv
verilog/wisc_cpu.sv
sim/wisc_cpu_props.sv
sim/wisc_checker.sv
sim/tb_wisc_cpu.sv

// ==== Bender.yml ====
package:
  name: wisc_cpu

sources:
  - verilog/wisc_pkg.sv
  - verilog/wisc_mem.sv
  - verilog/wisc_regfile.sv
  - verilog/wisc_alu.sv
  - verilog/wisc_branch.sv
  - verilog/wisc_hazard.sv
  - verilog/wisc_cpu.sv
  - target: simulation
    files:
      - sim/wisc_cpu_props.sv
      - sim/wisc_checker.sv
      - sim/tb_wisc_cpu.sv
